/* cpu_core.f */
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_regfile.sv
hw/cpu_ex.sv
hw/cpu_mem.sv
hw/cpu_core.sv
verif/cpu_core_tb.sv

/* Makefile */
TOP := cpu_core_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cpu_core.f -o V$(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing --assert -Wall --top-module cpu_core -f cpu_core.f

clean:
	rm -rf obj_dir

/* verif/cpu_core_tb.sv */
module cpu_core_tb import cpu_pkg::*;;

	logic        clk;
	logic        rst;
	logic        stall;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] ref_addr [$];
	logic [31:0] ref_data [$];
	logic        end_seen;
	logic [15:0] lfsr_state;
	int          cycles;
	int          wp;
	logic [31:0] st_off;
	logic [15:0] imm_a, imm_b, imm_c, imm_e;
	logic [4:0]  sh;

	cpu_core u_dut (.clk, .rst, .stall, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata,
		.dmem_we, .dmem_rdata);

	assign imem_data = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always #2 clk = ~clk;

	// the end store to 0x1fc closes a program; it and any store after it go unrecorded.
	always @(posedge clk) begin
		if (!rst && dmem_we) begin
			assert (!stall) else begin
				$display("a store pulse appeared while stall was high");
				$display("Checks failed");
				$fatal(1);
			end
			if (dmem_addr == 32'h1fc) begin
				end_seen <= 1'b1;
			end else if (!end_seen) begin
				st_addr.push_back(dmem_addr);
				st_data.push_back(dmem_wdata);
				dmem[dmem_addr[9:2]] = dmem_wdata;
			end
		end
	end

	// five tests of at most 200 cycles each, plus margin.
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 1200) begin
			$display("timeout: the tests did not finish within 1200 cycles");
			$display("Checks failed");
			$fatal(1);
		end
	end

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit.
	function automatic logic [31:0] lfsr_draw(input int nbits);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input funct_e f);
		return {OP_RTYPE, rs, rt, rd, shamt, f};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input opcode_e op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] sext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_value(input string name, input logic [31:0] expv,
		input logic [31:0] act);
		assert (expv == act) else begin
			$display("** Error %s: expected %h actual %h", name, expv, act);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic check_stores(input string name);
		check_value({name, " store count"}, exp_addr.size(), st_addr.size());
		for (int i = 0; i < exp_addr.size(); i++) begin
			check_value({name, " store address"}, exp_addr[i], st_addr[i]);
			check_value({name, " store data"}, exp_data[i], st_data[i]);
		end
	endtask

	// reset goes high and the memories are reloaded while the core is held.
	task automatic begin_test();
		@(posedge clk);
		rst <= 1'b1;
		stall <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = 32'h5a00_0000 | i;
		end
		wp = 0;
		st_off = 32'h100;
		exp_addr.delete();
		exp_data.delete();
	endtask

	// runs until the end store, with an optional stall window counted from reset release.
	task automatic run_program(input int stall_at, input int stall_len);
		int n;
		@(posedge clk);
		@(posedge clk);
		rst <= 1'b0;
		st_addr.delete();
		st_data.delete();
		end_seen <= 1'b0;
		n = 0;
		@(posedge clk);
		while (!end_seen) begin
			n++;
			if (stall_len > 0 && n == stall_at) stall <= 1'b1;
			if (stall_len > 0 && n == stall_at + stall_len) stall <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic alu_case(input logic [31:0] w, input logic [31:0] expv);
		emit(w);
		emit(enc_i(OP_SW, 5'd0, 5'd5, st_off[15:0]));
		expect_store(st_off, expv);
		st_off += 4;
	endtask

	task automatic alu_program();
		logic [31:0] va, vb, vd, ve;
		va = sext(imm_a);
		vb = {16'h0, imm_b};
		vd = {imm_c, 16'h0} | vb;
		ve = sext(imm_e);
		emit(enc_i(OP_ADDIU, 5'd0, 5'd1, imm_a));
		emit(enc_i(OP_ORI, 5'd0, 5'd2, imm_b));
		emit(enc_i(OP_LUI, 5'd0, 5'd3, imm_c));
		emit(enc_i(OP_ORI, 5'd3, 5'd4, imm_b));
		alu_case(enc_i(OP_ADDIU, 5'd0, 5'd5, imm_a), va);
		alu_case(enc_i(OP_LUI, 5'd0, 5'd5, imm_c), {imm_c, 16'h0});
		alu_case(enc_r(5'd1, 5'd4, 5'd5, 5'd0, F_ADDU), va + vd);
		alu_case(enc_r(5'd1, 5'd4, 5'd5, 5'd0, F_SUBU), va - vd);
		alu_case(enc_r(5'd4, 5'd1, 5'd5, 5'd0, F_AND), vd & va);
		alu_case(enc_r(5'd1, 5'd2, 5'd5, 5'd0, F_OR), va | vb);
		alu_case(enc_r(5'd1, 5'd4, 5'd5, 5'd0, F_NOR), ~(va | vd));
		alu_case(enc_r(5'd1, 5'd4, 5'd5, 5'd0, F_SLT), {31'd0, $signed(va) < $signed(vd)});
		alu_case(enc_r(5'd1, 5'd4, 5'd5, 5'd0, F_SLTU), {31'd0, va < vd});
		alu_case(enc_r(5'd0, 5'd4, 5'd5, sh, F_SLL), vd << sh);
		alu_case(enc_r(5'd0, 5'd4, 5'd5, sh, F_SRL), vd >> sh);
		alu_case(enc_i(OP_ADDIU, 5'd4, 5'd5, imm_e), vd + ve);
		alu_case(enc_i(OP_SLTI, 5'd1, 5'd5, imm_e), {31'd0, $signed(va) < $signed(ve)});
		alu_case(enc_i(OP_SLTIU, 5'd1, 5'd5, imm_e), {31'd0, va < ve});
		alu_case(enc_i(OP_ANDI, 5'd4, 5'd5, imm_e), vd & {16'h0, imm_e});
		alu_case(enc_i(OP_ORI, 5'd1, 5'd5, imm_e), va | {16'h0, imm_e});
		emit(enc_i(OP_SW, 5'd0, 5'd0, 16'h1fc));
	endtask

	task automatic test_alu();
		begin_test();
		imm_a = 16'(lfsr_draw(16));
		imm_b = 16'(lfsr_draw(16));
		imm_c = 16'(lfsr_draw(16));
		imm_e = 16'(lfsr_draw(16));
		sh = 5'(lfsr_draw(5));
		alu_program();
		run_program(0, 0);
		check_stores("alu");
		ref_addr = st_addr;
		ref_data = st_data;
	endtask

	task automatic test_forwarding();
		logic [15:0] k1, k2, k3;
		logic [31:0] e7, e9, e11;
		begin_test();
		k1 = 16'(lfsr_draw(16));
		k2 = 16'(lfsr_draw(16));
		k3 = 16'(lfsr_draw(16));
		e7 = sext(k1) + sext(k1);
		e9 = sext(k2) + e7;
		e11 = sext(k3) - e9;
		emit(enc_i(OP_ADDIU, 5'd0, 5'd6, k1));
		emit(enc_r(5'd6, 5'd6, 5'd7, 5'd0, F_ADDU));
		emit(enc_i(OP_ADDIU, 5'd0, 5'd8, k2));
		emit(32'h0);
		// r8 sits two instructions back and r7 three.
		emit(enc_r(5'd8, 5'd7, 5'd9, 5'd0, F_ADDU));
		emit(enc_i(OP_ADDIU, 5'd0, 5'd10, k3));
		emit(32'h0);
		emit(32'h0);
		emit(enc_r(5'd10, 5'd9, 5'd11, 5'd0, F_SUBU));
		emit(enc_i(OP_ADDIU, 5'd0, 5'd0, k1));
		emit(enc_r(5'd0, 5'd0, 5'd12, 5'd0, F_ADDU));
		emit(enc_i(OP_SW, 5'd0, 5'd7, 16'h100));
		emit(enc_i(OP_SW, 5'd0, 5'd9, 16'h104));
		emit(enc_i(OP_SW, 5'd0, 5'd11, 16'h108));
		emit(enc_i(OP_SW, 5'd0, 5'd12, 16'h10c));
		emit(enc_i(OP_SW, 5'd0, 5'd0, 16'h1fc));
		expect_store(32'h100, e7);
		expect_store(32'h104, e9);
		expect_store(32'h108, e11);
		expect_store(32'h10c, 32'h0);
		run_program(0, 0);
		check_stores("forwarding");
	endtask

	task automatic test_load_store();
		logic [31:0] p1, p2, ks;
		logic [15:0] k;
		begin_test();
		p1 = lfsr_draw(32);
		p2 = lfsr_draw(32);
		k = 16'(lfsr_draw(16));
		ks = sext(k);
		dmem[32] = p1;
		dmem[33] = p2;
		emit(enc_i(OP_ADDIU, 5'd0, 5'd13, k));
		emit(enc_i(OP_LW, 5'd0, 5'd14, 16'h80));
		emit(32'h0);
		emit(enc_r(5'd14, 5'd13, 5'd15, 5'd0, F_ADDU));
		emit(enc_i(OP_SW, 5'd0, 5'd15, 16'h180));
		emit(enc_i(OP_LW, 5'd0, 5'd16, 16'h84));
		emit(32'h0);
		emit(enc_i(OP_SW, 5'd0, 5'd16, 16'h184));
		emit(enc_i(OP_SW, 5'd0, 5'd13, 16'h88));
		emit(enc_i(OP_LW, 5'd0, 5'd17, 16'h88));
		emit(32'h0);
		emit(enc_i(OP_SW, 5'd0, 5'd17, 16'h18c));
		emit(enc_i(OP_SW, 5'd0, 5'd0, 16'h1fc));
		expect_store(32'h180, p1 + ks);
		expect_store(32'h184, p2);
		expect_store(32'h88, ks);
		expect_store(32'h18c, ks);
		run_program(0, 0);
		check_stores("load_store");
	endtask

	// word indices are fixed so that the branch offsets and jump targets stay readable.
	task automatic test_control_flow();
		begin_test();
		emit(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'd1));
		emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd2));
		// the first two branches fall through, all later ones are taken.
		emit(enc_i(OP_BEQ, 5'd1, 5'd2, 16'd2));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h130));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h134));
		emit(enc_i(OP_BNE, 5'd1, 5'd1, 16'd2));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h138));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h13c));
		emit(enc_i(OP_BEQ, 5'd1, 5'd1, 16'd2));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h100));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h104));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h108));
		emit(enc_i(OP_BNE, 5'd1, 5'd2, 16'd2));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h10c));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h110));
		emit(enc_j(OP_J, 26'd18));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h114));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h118));
		emit(enc_j(OP_JAL, 26'd22));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h11c));
		emit(enc_i(OP_SW, 5'd0, 5'd31, 16'h120));
		emit(enc_i(OP_SW, 5'd0, 5'd0, 16'h1fc));
		emit(enc_i(OP_SW, 5'd0, 5'd31, 16'h124));
		emit(enc_r(5'd31, 5'd0, 5'd0, 5'd0, F_JR));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h128));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h12c));
		expect_store(32'h130, 32'd1);
		expect_store(32'h134, 32'd2);
		expect_store(32'h138, 32'd1);
		expect_store(32'h13c, 32'd2);
		expect_store(32'h100, 32'd1);
		expect_store(32'h108, 32'd2);
		expect_store(32'h10c, 32'd1);
		expect_store(32'h114, 32'd1);
		expect_store(32'h11c, 32'd2);
		// jal sits at byte address 72, so r31 holds 80.
		expect_store(32'h124, 32'd80);
		expect_store(32'h128, 32'd1);
		expect_store(32'h120, 32'd80);
		run_program(0, 0);
		check_stores("control_flow");
	endtask

	task automatic test_stall();
		int len;
		begin_test();
		alu_program();
		len = 2 + lfsr_draw(4);
		run_program(12, len);
		exp_addr = ref_addr;
		exp_data = ref_data;
		check_stores("stall");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		end_seen = 1'b0;
		cycles = 0;
		lfsr_state = 16'd44;
		test_alu();
		test_forwarding();
		test_load_store();
		test_control_flow();
		test_stall();
		$display("All checks passed");
		$finish;
	end

endmodule

/* hw/cpu_core.sv */
`include "cpu_config.svh"

module cpu_core import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	output logic [`CPU_XLEN-1:0] imem_addr,
	input  logic [`CPU_XLEN-1:0] imem_data,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	output logic                 dmem_we,
	input  logic [`CPU_XLEN-1:0] dmem_rdata
);

	if_id_t               if_id;
	id_ex_t               id_ex;
	ex_mem_t              ex_mem;
	wb_t                  wb;
	logic [4:0]           rf_raddr_a;
	logic [4:0]           rf_raddr_b;
	logic [`CPU_XLEN-1:0] rf_rdata_a;
	logic [`CPU_XLEN-1:0] rf_rdata_b;
	logic                 take_branch;
	logic                 take_jump;
	logic [`CPU_XLEN-1:0] branch_target;
	logic [`CPU_XLEN-1:0] jump_target;

	cpu_fetch u_fetch (.clk, .rst, .stall, .take_branch, .take_jump, .branch_target,
		.jump_target, .imem_data, .imem_addr, .if_id);

	cpu_decode u_decode (.clk, .rst, .stall, .if_id, .rf_rdata_a, .rf_rdata_b,
		.rf_raddr_a, .rf_raddr_b, .id_ex);

	cpu_regfile u_regfile (.clk, .rst, .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
		.rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b), .wb);

	// writeback feeds both the register file and the second forwarding path.
	cpu_ex u_ex (.clk, .rst, .stall, .id_ex, .wb, .ex_mem, .take_branch, .take_jump,
		.branch_target, .jump_target);

	cpu_mem u_mem (.clk, .rst, .stall, .ex_mem, .dmem_rdata, .dmem_addr, .dmem_wdata,
		.dmem_we, .wb);

endmodule

/* hw/cpu_mem.sv */
`include "cpu_config.svh"

module cpu_mem import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  ex_mem_t              ex_mem,
	input  logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	output logic                 dmem_we,
	output wb_t                  wb
);

	wb_t wb_d;

	assign dmem_addr = ex_mem.alu_r;
	assign dmem_wdata = ex_mem.rfb;

	// EX/MEM holds during a stall, so without this gate a store would repeat.
	assign dmem_we = ex_mem.drw && !stall;

	always_comb begin
		wb_d.rfw = ex_mem.rfw;
		wb_d.waddr = ex_mem.waddr;
		case (ex_mem.wb_src)
			WB_MEM: wb_d.wdata = dmem_rdata;
			WB_LINK: wb_d.wdata = ex_mem.jalra;
			default: wb_d.wdata = ex_mem.alu_r;
		endcase
	end

	// load data is sampled at the first edge without stall.
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.rfw <= 1'b0;
		end else if (!stall) begin
			wb <= wb_d;
		end
	end

	a_store_aligned: assert property (@(posedge clk) disable iff (rst)
		dmem_we |-> dmem_addr[1:0] == 2'b00);

endmodule

/* hw/cpu_ex.sv */
`include "cpu_config.svh"

module cpu_ex import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  id_ex_t               id_ex,
	input  wb_t                  wb,
	output ex_mem_t              ex_mem,
	output logic                 take_branch,
	output logic                 take_jump,
	output logic [`CPU_XLEN-1:0] branch_target,
	output logic [`CPU_XLEN-1:0] jump_target
);

	logic [`CPU_XLEN-1:0] mem_fwd;
	logic [`CPU_XLEN-1:0] x;
	logic [`CPU_XLEN-1:0] eff_y;
	logic [`CPU_XLEN-1:0] y;
	logic [`CPU_XLEN-1:0] alu_r;
	logic [`CPU_XLEN-1:0] pc_4;
	logic [4:0]           shamt;
	alu_op_e              alu_op;
	ex_mem_t              ex_mem_d;

	// the older instruction in MEM forwards its link address when it is a jal.
	assign mem_fwd = (ex_mem.wb_src == WB_LINK) ? ex_mem.jalra : ex_mem.alu_r;

	// the nearest producer wins; r0 is never a forwarding source.
	assign x = (ex_mem.rfw && ex_mem.waddr != 5'd0 && ex_mem.waddr == id_ex.rs) ? mem_fwd :
	           (wb.rfw && wb.waddr != 5'd0 && wb.waddr == id_ex.rs) ? wb.wdata : id_ex.rfa;
	assign eff_y = (ex_mem.rfw && ex_mem.waddr != 5'd0 && ex_mem.waddr == id_ex.rt) ? mem_fwd :
	               (wb.rfw && wb.waddr != 5'd0 && wb.waddr == id_ex.rt) ? wb.wdata : id_ex.rfb;
	assign y = id_ex.rfbse ? id_ex.imm : eff_y;

	always_comb begin
		case (id_ex.alu_ctl)
			OP_RTYPE: alu_op = (id_ex.funct == F_JR) ? ALU_ADD : alu_op_e'(id_ex.funct);
			OP_SLTI: alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI: alu_op = ALU_AND;
			OP_ORI: alu_op = ALU_OR;
			OP_LUI: alu_op = ALU_SLL;
			// beq asks for "not equal" so that a zero result means taken.
			OP_BEQ: alu_op = ALU_NE;
			OP_BNE: alu_op = ALU_EQ;
			default: alu_op = ALU_ADD;
		endcase
	end

	assign shamt = (id_ex.alu_ctl == OP_LUI) ? 5'd16 : id_ex.shamt;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_r = x + y;
			ALU_SUB: alu_r = x - y;
			ALU_AND: alu_r = x & y;
			ALU_OR: alu_r = x | y;
			ALU_NOR: alu_r = ~(x | y);
			ALU_SLT: alu_r = `CPU_XLEN'($signed(x) < $signed(y));
			ALU_SLTU: alu_r = `CPU_XLEN'(x < y);
			ALU_SLL: alu_r = y << shamt;
			ALU_SRL: alu_r = y >> shamt;
			ALU_NE: alu_r = `CPU_XLEN'(x != y);
			ALU_EQ: alu_r = `CPU_XLEN'(x == y);
			default: alu_r = '0;
		endcase
	end

	assign pc_4 = id_ex.pc + `CPU_XLEN'(4);
	assign take_jump = id_ex.j;
	assign take_branch = id_ex.b && (alu_r == '0);
	assign branch_target = pc_4 + {id_ex.imm[`CPU_XLEN-3:0], 2'b00};
	assign jump_target = id_ex.jjr ? x : {pc_4[31:28], id_ex.jaddr, 2'b00};

	always_comb begin
		ex_mem_d.rfw = id_ex.rfw;
		ex_mem_d.wb_src = id_ex.wb_src;
		ex_mem_d.drw = id_ex.drw;
		ex_mem_d.alu_r = alu_r;
		ex_mem_d.rfb = eff_y;
		ex_mem_d.waddr = id_ex.waddr;
		ex_mem_d.jalra = id_ex.pc + `CPU_XLEN'(8);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.rfw <= 1'b0;
			ex_mem.drw <= 1'b0;
		end else if (!stall) begin
			ex_mem <= ex_mem_d;
		end
	end

	a_single_redirect: assert property (@(posedge clk) disable iff (rst)
		!(take_branch && take_jump));

endmodule

/* hw/cpu_regfile.sv */
`include "cpu_config.svh"

module cpu_regfile import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [4:0]           raddr_a,
	input  logic [4:0]           raddr_b,
	output logic [`CPU_XLEN-1:0] rdata_a,
	output logic [`CPU_XLEN-1:0] rdata_b,
	input  wb_t                  wb
);

	logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-1];
	logic                 wr_en;

	// r0 is never written, so its entry stays unused.
	assign wr_en = wb.rfw && (wb.waddr != 5'd0) && !rst;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wb.waddr] <= wb.wdata;
		end
	end

	// a write in this cycle is visible to decode at once.
	assign rdata_a = (raddr_a == 5'd0) ? '0 :
	                 (wr_en && wb.waddr == raddr_a) ? wb.wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? '0 :
	                 (wr_en && wb.waddr == raddr_b) ? wb.wdata : regs[raddr_b];

endmodule

/* hw/cpu_decode.sv */
`include "cpu_config.svh"

module cpu_decode import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  if_id_t               if_id,
	input  logic [`CPU_XLEN-1:0] rf_rdata_a,
	input  logic [`CPU_XLEN-1:0] rf_rdata_b,
	output logic [4:0]           rf_raddr_a,
	output logic [4:0]           rf_raddr_b,
	output id_ex_t               id_ex
);

	id_ex_t  id_ex_d;
	opcode_e op;
	funct_e  fn;
	logic    known;

	assign op = opcode_e'(if_id.instr[31:26]);
	assign fn = funct_e'(if_id.instr[5:0]);

	assign rf_raddr_a = if_id.instr[25:21];
	assign rf_raddr_b = if_id.instr[20:16];

	always_comb begin
		id_ex_d = '0;
		known = 1'b1;
		id_ex_d.alu_ctl = op;
		id_ex_d.funct = fn;
		id_ex_d.rfa = rf_rdata_a;
		id_ex_d.rfb = rf_rdata_b;
		id_ex_d.shamt = if_id.instr[10:6];
		id_ex_d.rs = if_id.instr[25:21];
		id_ex_d.rt = if_id.instr[20:16];
		id_ex_d.pc = if_id.pc;
		id_ex_d.jaddr = if_id.instr[25:0];
		id_ex_d.imm = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
		id_ex_d.waddr = if_id.instr[20:16];
		case (op)
			OP_RTYPE: begin
				id_ex_d.waddr = if_id.instr[15:11];
				case (fn)
					F_JR: begin
						id_ex_d.j = 1'b1;
						id_ex_d.jjr = 1'b1;
					end
					F_SLL, F_SRL, F_ADDU, F_SUBU, F_AND, F_OR, F_NOR, F_SLT, F_SLTU:
						id_ex_d.rfw = 1'b1;
					default: known = 1'b0;
				endcase
			end
			OP_J: id_ex_d.j = 1'b1;
			OP_JAL: begin
				id_ex_d.j = 1'b1;
				id_ex_d.rfw = 1'b1;
				id_ex_d.wb_src = WB_LINK;
				id_ex_d.waddr = 5'(`CPU_LINK_REG);
			end
			OP_BEQ, OP_BNE: id_ex_d.b = 1'b1;
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				id_ex_d.rfw = 1'b1;
				id_ex_d.rfbse = 1'b1;
			end
			// logical immediates are zero extended; lui is shifted later in the ALU.
			OP_ANDI, OP_ORI, OP_LUI: begin
				id_ex_d.rfw = 1'b1;
				id_ex_d.rfbse = 1'b1;
				id_ex_d.imm = {16'h0000, if_id.instr[15:0]};
			end
			OP_LW: begin
				id_ex_d.rfw = 1'b1;
				id_ex_d.rfbse = 1'b1;
				id_ex_d.wb_src = WB_MEM;
			end
			OP_SW: begin
				id_ex_d.drw = 1'b1;
				id_ex_d.rfbse = 1'b1;
			end
			default: known = 1'b0;
		endcase
		// squashed fetches and unknown encodings travel on as bubbles.
		if (!if_id.valid || !known) begin
			id_ex_d.rfw = 1'b0;
			id_ex_d.drw = 1'b0;
			id_ex_d.j = 1'b0;
			id_ex_d.b = 1'b0;
			id_ex_d.jjr = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.rfw <= 1'b0;
			id_ex.drw <= 1'b0;
			id_ex.j <= 1'b0;
			id_ex.b <= 1'b0;
			id_ex.jjr <= 1'b0;
		end else if (!stall) begin
			id_ex <= id_ex_d;
		end
	end

	a_no_branch_and_jump: assert property (@(posedge clk) disable iff (rst) !(id_ex.b && id_ex.j));

endmodule

/* hw/cpu_fetch.sv */
`include "cpu_config.svh"

module cpu_fetch import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic                 take_branch,
	input  logic                 take_jump,
	input  logic [`CPU_XLEN-1:0] branch_target,
	input  logic [`CPU_XLEN-1:0] jump_target,
	input  logic [`CPU_XLEN-1:0] imem_data,
	output logic [`CPU_XLEN-1:0] imem_addr,
	output if_id_t               if_id
);

	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] pc_next;
	logic                 redirect;

	// a jump and a branch cannot both resolve in one cycle, but the jump wins anyway.
	assign redirect = take_jump | take_branch;
	assign pc_next  = take_jump ? jump_target :
	                  take_branch ? branch_target : pc + `CPU_XLEN'(4);

	assign imem_addr = pc;

	// the word fetched while EX redirects lies past the delay slot, so it becomes a bubble.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc_next;
			if_id.pc <= pc;
			if_id.instr <= imem_data;
			if_id.valid <= !redirect;
		end
	end

	// targets come from execute; a misaligned one would break every later fetch.
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* hw/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

	// primary opcodes, values as in the MIPS encoding.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	// the ALU shares the R-type function codes; the two compares take the branch opcodes.
	typedef enum logic [5:0] {
		ALU_SLL  = 6'h00,
		ALU_SRL  = 6'h02,
		ALU_NE   = 6'h04,
		ALU_EQ   = 6'h05,
		ALU_ADD  = 6'h21,
		ALU_SUB  = 6'h23,
		ALU_AND  = 6'h24,
		ALU_OR   = 6'h25,
		ALU_NOR  = 6'h27,
		ALU_SLT  = 6'h2a,
		ALU_SLTU = 6'h2b
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2
	} wb_src_e;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] instr;
		logic                 valid;
	} if_id_t;

	typedef struct packed {
		logic                 rfw;
		wb_src_e              wb_src;
		logic                 drw;
		opcode_e              alu_ctl;
		logic                 j;
		logic                 b;
		logic                 jjr;
		logic                 rfbse;
		logic [`CPU_XLEN-1:0] rfa;
		logic [`CPU_XLEN-1:0] rfb;
		logic [`CPU_XLEN-1:0] imm;
		logic [4:0]           shamt;
		funct_e               funct;
		logic [4:0]           waddr;
		logic [4:0]           rs;
		logic [4:0]           rt;
		logic [`CPU_XLEN-1:0] pc;
		logic [25:0]          jaddr;
	} id_ex_t;

	typedef struct packed {
		logic                 rfw;
		wb_src_e              wb_src;
		logic                 drw;
		logic [`CPU_XLEN-1:0] alu_r;
		logic [`CPU_XLEN-1:0] rfb;
		logic [4:0]           waddr;
		logic [`CPU_XLEN-1:0] jalra;
	} ex_mem_t;

	typedef struct packed {
		logic                 rfw;
		logic [4:0]           waddr;
		logic [`CPU_XLEN-1:0] wdata;
	} wb_t;

endpackage

/* hw/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and address width.
`define CPU_XLEN 32

// architectural register count, r0 included.
`define CPU_NREGS 32

// first fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

// jal writes its return address here.
`define CPU_LINK_REG 31

`endif
